// ==== hw/crc32_serial.sv ====
`timescale 1ns/1ps

module crc32_serial (
  input  logic      CLK,
  crc_bus_if.engine crc
);

  eth_tx_pkg::crc_t crc_q;
  logic fb;

  // feedback of the outgoing bit against the incoming one.
  assign fb = crc_q[0] ^ crc.data_bit;

  always_ff @(posedge CLK)
  begin
    if (crc.clear)
      crc_q <= eth_tx_pkg::crc_init;
    else if (crc.write && !crc.halt)
    begin
      if (fb)
        crc_q <= {1'b0, crc_q[31:1]} ^ eth_tx_pkg::crc_poly;
      else
        crc_q <= {1'b0, crc_q[31:1]};
    end
  end

  // fcs is the inverted remainder.
  assign crc.value = ~crc_q;

endmodule

// ==== hw/crc_bus_if.sv ====
`timescale 1ns/1ps

interface crc_bus_if;

  logic clear;                 // load crc_init.
  logic data_bit;              // next payload bit, lsb first.
  logic write;
  logic halt;                  // freeze after the last payload bit.
  eth_tx_pkg::crc_t value;     // complemented register, the fcs.

  modport driver (output clear, output data_bit, output write, output halt);

  modport engine (input clear, input data_bit, input write, input halt, output value);

  modport monitor (input value);

endinterface

// ==== hw/eth_tx_pkg.sv ====
package eth_tx_pkg;

  localparam int len_w = 11;  // byte count of one payload.
  localparam int word_w = 32;
  localparam int half_w = 16;
  localparam int crc_w = 32;

  typedef logic [len_w-1:0] len_t;
  typedef logic [word_w-1:0] word_t;
  typedef logic [half_w-1:0] half_t;
  typedef logic [crc_w-1:0] crc_t;

  // frame layout on the wire.
  localparam int preamble_octets = 7;
  localparam logic [7:0] preamble_byte = 8'h55;
  localparam logic [7:0] sfd_byte = 8'hD5;

  // bit times of idle high after the fcs.
  localparam int eot_bits = 2;

  // reflected ieee 802.3 polynomial, shifted lsb first.
  localparam crc_t crc_poly = 32'hEDB88320;
  localparam crc_t crc_init = '1;

endpackage

// ==== hw/eth_tx_top.sv ====
`timescale 1ns/1ps

module eth_tx_top #(
  parameter int buf_depth = 512,
  localparam int addr_w = $clog2(buf_depth)
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               buf_we,
  input  logic [addr_w-1:0]  buf_waddr,
  input  eth_tx_pkg::word_t  buf_wdata,
  input  logic               send_req,
  input  logic               send_pulse,
  input  eth_tx_pkg::len_t   send_len,
  output logic               send_ack,
  output logic               tx_wire,
  output logic               tx_active
);

  logic [addr_w-1:0] rd_addr;
  eth_tx_pkg::word_t rd_data;
  logic bit_en;
  logic frame_rst_n;
  logic pulse;
  logic bit_out;
  logic eot;

  crc_bus_if crc_bus ();
  octet_bus_if oct_bus ();

  frame_buffer #(.buf_depth(buf_depth)) u_buf (
    .CLK(CLK), .buf_we(buf_we), .buf_waddr(buf_waddr), .buf_wdata(buf_wdata),
    .rd_addr(rd_addr), .rd_data(rd_data)
  );

  tx_fetch #(.buf_depth(buf_depth)) u_fetch (
    .CLK(CLK), .frame_rst_n(frame_rst_n), .bit_en(bit_en), .send_len(send_len),
    .rd_addr(rd_addr), .rd_data(rd_data), .octets(oct_bus.source), .crc(crc_bus.driver)
  );

  crc32_serial u_crc (.CLK(CLK), .crc(crc_bus.engine));

  tx_serializer u_ser (
    .CLK(CLK), .frame_rst_n(frame_rst_n), .bit_en(bit_en), .octets(oct_bus.sink),
    .crc(crc_bus.monitor), .bit_out(bit_out), .eot(eot)
  );

  // coder phase restarts with every frame.
  manchester_enc u_enc (
    .CLK(CLK), .RST(RST), .active(frame_rst_n), .bit_in(bit_out), .eot(eot),
    .pulse(pulse), .tx_wire(tx_wire)
  );

  tx_control u_ctl (
    .CLK(CLK), .RST(RST), .send_req(send_req), .send_pulse(send_pulse), .eot(eot),
    .send_ack(send_ack), .bit_en(bit_en), .frame_rst_n(frame_rst_n), .pulse(pulse),
    .tx_active(tx_active)
  );

endmodule

// ==== hw/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer #(
  parameter int buf_depth = 512,
  localparam int addr_w = $clog2(buf_depth)
) (
  input  logic               CLK,
  input  logic               buf_we,
  input  logic [addr_w-1:0]  buf_waddr,
  input  eth_tx_pkg::word_t  buf_wdata,
  input  logic [addr_w-1:0]  rd_addr,
  output eth_tx_pkg::word_t  rd_data
);

  // payload words, first byte of the frame in bits 31:24.
  eth_tx_pkg::word_t mem [buf_depth];

  // host side write.
  always_ff @(posedge CLK)
  begin
    if (buf_we)
      mem[buf_waddr] <= buf_wdata;
  end

  // one clock read latency.
  always_ff @(posedge CLK)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== hw/manchester_enc.sv ====
`timescale 1ns/1ps

module manchester_enc (
  input  logic CLK,
  input  logic RST,
  input  logic active,
  input  logic bit_in,
  input  logic eot,
  input  logic pulse,
  output logic tx_wire
);

  logic phase;  // high in the second half of a bit.
  logic [1:0] pulse_cnt;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      phase <= 1'b0;
      pulse_cnt <= '0;
      tx_wire <= 1'b0;
    end
    else
    begin
      // half-bit phase follows bit_en from the frame start.
      if (active)
        phase <= !phase;
      else
        phase <= 1'b0;

      if (pulse)
      begin
        // link pulse, two clocks high then low.
        if (pulse_cnt != 2'd2)
          pulse_cnt <= pulse_cnt + 2'd1;
        tx_wire <= (pulse_cnt != 2'd2);
      end
      else
      begin
        pulse_cnt <= '0;
        if (!active)
          tx_wire <= 1'b0;
        else if (eot)
          tx_wire <= 1'b1;  // end of transmission high.
        else if (phase)
          tx_wire <= bit_in;
        else
          tx_wire <= !bit_in;
      end
    end
  end

endmodule

// ==== hw/octet_bus_if.sv ====
`timescale 1ns/1ps

interface octet_bus_if;

  logic octet;                 // last bit_en of an octet.
  logic last_data;             // payload fully fed through the crc.
  eth_tx_pkg::half_t half;     // next halfword for the wire.
  logic run;                   // first halfword staged.

  modport source (output octet, output last_data, output half, output run);

  modport sink (input octet, input last_data, input half, input run);

endinterface

// ==== hw/tx_control.sv ====
`timescale 1ns/1ps

module tx_control (
  input  logic CLK,
  input  logic RST,
  input  logic send_req,
  input  logic send_pulse,
  input  logic eot,
  output logic send_ack,
  output logic bit_en,
  output logic frame_rst_n,
  output logic pulse,
  output logic tx_active
);

  typedef enum logic [2:0] {
    st_idle,
    st_frame,
    st_end_high,
    st_pulse,
    st_ack,
    st_wait
  } ctl_state_t;

  ctl_state_t state;
  logic [1:0] cnt;  // end-high bit times or pulse clocks.

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state <= st_idle;
      cnt <= '0;
      send_ack <= 1'b0;
      bit_en <= 1'b0;
      frame_rst_n <= 1'b0;
      pulse <= 1'b0;
      tx_active <= 1'b0;
    end
    else
    begin
      tx_active <= frame_rst_n;  // wire lags frame_rst_n by one clock.
      case (state)
        st_idle:
        begin
          cnt <= '0;
          if (send_req && send_pulse)
          begin
            pulse <= 1'b1;
            state <= st_pulse;
          end
          else if (send_req)
          begin
            frame_rst_n <= 1'b1;
            state <= st_frame;
          end
        end
        st_frame:
        begin
          bit_en <= !bit_en;
          if (eot)
            state <= st_end_high;
        end
        st_end_high:
        begin
          bit_en <= !bit_en;
          if (bit_en)
          begin
            cnt <= cnt + 2'd1;
            if (cnt == 2'(eth_tx_pkg::eot_bits - 1))
            begin
              bit_en <= 1'b0;
              frame_rst_n <= 1'b0;
              state <= st_ack;
            end
          end
        end
        st_pulse:
        begin
          cnt <= cnt + 2'd1;
          if (cnt == 2'd2)
          begin
            pulse <= 1'b0;
            state <= st_ack;
          end
        end
        st_ack:
        begin
          send_ack <= 1'b1;
          state <= st_wait;
        end
        default:
        begin
          // hold ack until the host lets go of the request.
          if (!send_req)
          begin
            send_ack <= 1'b0;
            state <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

// ==== hw/tx_fetch.sv ====
`timescale 1ns/1ps

module tx_fetch #(
  parameter int buf_depth = 512,
  localparam int addr_w = $clog2(buf_depth)
) (
  input  logic               CLK,
  input  logic               frame_rst_n,
  input  logic               bit_en,
  input  eth_tx_pkg::len_t   send_len,
  output logic [addr_w-1:0]  rd_addr,
  input  eth_tx_pkg::word_t  rd_data,
  octet_bus_if.source        octets,
  crc_bus_if.driver          crc
);

  // the crc runs two octets ahead of the wire, so the fcs is
  // settled well before the serializer loads it.
  localparam int lead_octets = 2;
  localparam int first_take = eth_tx_pkg::preamble_octets - lead_octets;

  logic [2:0] bit_cnt;
  logic [2:0] pre_cnt;
  eth_tx_pkg::len_t byte_cnt;
  logic in_pay;
  logic last_q;
  logic run_q;
  logic [7:0] crc_byte;
  logic [7:0] next_byte;
  eth_tx_pkg::half_t half_q;
  logic pay_slot;
  logic take;

  assign octets.octet = bit_en && (bit_cnt == 3'd7);
  assign octets.last_data = last_q;
  assign octets.half = half_q;
  assign octets.run = run_q;

  // octet boundary in the payload part of the schedule.
  assign pay_slot = octets.octet && (in_pay || pre_cnt == 3'(first_take));
  assign take = pay_slot && (byte_cnt != send_len);

  assign crc.clear = !in_pay;  // held in init through the preamble.
  assign crc.data_bit = crc_byte[0];
  assign crc.write = bit_en && in_pay;
  assign crc.halt = last_q;

  // byte of the current word, msb first.
  always_comb
  begin
    case (byte_cnt[1:0])
      2'd0: next_byte = rd_data[31:24];
      2'd1: next_byte = rd_data[23:16];
      2'd2: next_byte = rd_data[15:8];
      default: next_byte = rd_data[7:0];
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!frame_rst_n)
    begin
      bit_cnt <= '0;
      pre_cnt <= '0;
      byte_cnt <= '0;
      rd_addr <= '0;
      in_pay <= 1'b0;
      last_q <= 1'b0;
      run_q <= 1'b0;
    end
    else if (bit_en)
    begin
      bit_cnt <= bit_cnt + 3'd1;
      if (octets.octet && !pay_slot)
        pre_cnt <= pre_cnt + 3'd1;  // still in preamble time.
      if (pay_slot)
      begin
        in_pay <= 1'b1;
        if (byte_cnt == send_len)
          last_q <= 1'b1;
      end
      if (take)
      begin
        byte_cnt <= byte_cnt + 1'b1;
        run_q <= 1'b1;
        if (byte_cnt[1:0] == 2'd3)
          rd_addr <= rd_addr + 1'b1;  // word used up.
      end
    end
  end

  // byte shifter for the crc and the halfword stage.
  always_ff @(posedge CLK)
  begin
    if (bit_en)
    begin
      if (take)
      begin
        crc_byte <= next_byte;
        if (!byte_cnt[0])
          half_q <= byte_cnt[1] ? rd_data[15:0] : rd_data[31:16];
      end
      else
        crc_byte <= {1'b0, crc_byte[7:1]};
    end
  end

endmodule

// ==== hw/tx_serializer.sv ====
`timescale 1ns/1ps

module tx_serializer (
  input  logic        CLK,
  input  logic        frame_rst_n,
  input  logic        bit_en,
  octet_bus_if.sink   octets,
  crc_bus_if.monitor  crc,
  output logic        bit_out,
  output logic        eot
);

  // preamble pairs loaded after the one held at reset, before the sfd pair.
  localparam int pre_loads = (eth_tx_pkg::preamble_octets - 3) / 2;

  localparam logic [15:0] pre_pair = {eth_tx_pkg::preamble_byte, eth_tx_pkg::preamble_byte};
  localparam logic [15:0] sfd_pair = {eth_tx_pkg::sfd_byte, eth_tx_pkg::preamble_byte};

  typedef enum logic [2:0] {
    s_pre,
    s_pay,
    s_fcs_hi,
    s_tail,
    s_eot
  } ser_state_t;

  ser_state_t state;
  logic [15:0] sreg;
  logic high;  // second octet of a pair.
  logic [1:0] pre_cnt;

  assign bit_out = sreg[0];

  always_ff @(posedge CLK)
  begin
    if (!frame_rst_n)
    begin
      sreg <= pre_pair;  // first two preamble octets.
      high <= 1'b0;
      pre_cnt <= '0;
      state <= s_pre;
      eot <= 1'b0;
    end
    else if (bit_en)
    begin
      sreg <= {1'b0, sreg[15:1]};
      if (octets.octet)
      begin
        high <= !high;
        if (high)
        begin
          case (state)
            s_pre:
            begin
              if (pre_cnt == 2'(pre_loads))
              begin
                sreg <= sfd_pair;
                state <= s_pay;
              end
              else
              begin
                sreg <= pre_pair;
                pre_cnt <= pre_cnt + 2'd1;
              end
            end
            s_pay:
            begin
              if (octets.last_data)
              begin
                sreg <= crc.value[15:0];  // fcs, low half first.
                state <= s_fcs_hi;
              end
              else if (octets.run)
                sreg <= {octets.half[7:0], octets.half[15:8]};
            end
            s_fcs_hi:
            begin
              sreg <= crc.value[31:16];
              state <= s_tail;
            end
            s_tail:
            begin
              eot <= 1'b1;  // last fcs bit has gone out.
              state <= s_eot;
            end
            default:
            begin
              state <= s_eot;
            end
          endcase
        end
      end
    end
  end

endmodule

// ==== sources.f ====
hw/eth_tx_pkg.sv
hw/crc_bus_if.sv
hw/octet_bus_if.sv
hw/frame_buffer.sv
hw/tx_fetch.sv
hw/crc32_serial.sv
hw/tx_serializer.sv
hw/manchester_enc.sv
hw/tx_control.sv
hw/eth_tx_top.sv
tb/eth_tx_props.sv
tb/eth_tx_tb.sv

// ==== tb/eth_tx_golden.hex ====
// columns: type (0 frame, 1 link pulse, 2 end), length in bytes,
// payload words with the first byte in bits 31:24, expected fcs
// "ab"
00000000 00000002 61620000 9E83486D
00000001 00000000 00000000
// four ff bytes
00000000 00000004 FFFFFFFF FFFFFFFF
// "abcd"
00000000 00000004 61626364 ED82CD11
// "abcdef"
00000000 00000006 61626364 65660000 4B8E39EF
00000001 00000000 00000000
// "abcdefgh"
00000000 00000008 61626364 65666768 AEEF2A50
// "abcdefghij"
00000000 0000000A 61626364 65666768 696A0000 3981703A
// "message digest"
00000000 0000000E 6D657373 61676520 64696765 73740000 20159D7F
00000001 00000000 00000000
// lower case alphabet
00000000 0000001A 61626364 65666768 696A6B6C 6D6E6F70
71727374 75767778 797A0000 4C2750BD
// upper case, lower case and digits
00000000 0000003E 41424344 45464748 494A4B4C 4D4E4F50
51525354 55565758 595A6162 63646566
6768696A 6B6C6D6E 6F707172 73747576
7778797A 30313233 34353637 38390000
1FC2E6D2
00000001 00000000 00000000
00000002

// ==== tb/eth_tx_props.sv ====
`timescale 1ns/1ps

module eth_tx_props (
  input logic CLK,
  input logic RST,
  input logic send_req,
  input logic send_ack,
  input logic tx_wire,
  input logic tx_active,
  input logic pulse
);

  int unsigned fail_cnt = 0;  // assertion failures so far.

  ack_rise_in_req: assert property (@(posedge CLK) disable iff (!RST)
    $rose(send_ack) |-> send_req)
    else
    begin
      fail_cnt++;
      $error("send_ack rose while send_req was low");
    end

  ack_held_for_req: assert property (@(posedge CLK) disable iff (!RST)
    send_ack && send_req |=> send_ack)
    else
    begin
      fail_cnt++;
      $error("send_ack fell before send_req was released");
    end

  wire_idle_low: assert property (@(posedge CLK) disable iff (!RST)
    !tx_active && !pulse |-> !tx_wire)
    else
    begin
      fail_cnt++;
      $error("tx_wire high with no frame and no link pulse");
    end

  // link pulse is two clocks wide.
  pulse_width: assert property (@(posedge CLK) disable iff (!RST)
    $rose(tx_wire) && !tx_active |=> tx_wire ##1 !tx_wire)
    else
    begin
      fail_cnt++;
      $error("link pulse width is not 2 clocks");
    end

endmodule

bind eth_tx_top eth_tx_props u_props (
  .CLK(CLK), .RST(RST), .send_req(send_req), .send_ack(send_ack), .tx_wire(tx_wire),
  .tx_active(tx_active), .pulse(pulse)
);

// ==== tb/eth_tx_tb.sv ====
`timescale 1ns/1ps

module eth_tx_tb;

  localparam int buf_depth = 512;
  localparam int addr_w = $clog2(buf_depth);
  localparam int gold_size = 512;
  localparam int max_gap = 8;  // idle clocks between commands.
  localparam int hdr_octets = eth_tx_pkg::preamble_octets + 1;

  logic CLK;
  logic RST;
  logic buf_we;
  logic [addr_w-1:0] buf_waddr;
  eth_tx_pkg::word_t buf_wdata;
  logic send_req;
  logic send_pulse;
  eth_tx_pkg::len_t send_len;
  logic send_ack;
  logic tx_wire;
  logic tx_active;

  eth_tx_pkg::word_t gold [gold_size];
  logic halves [$];  // wire samples while tx_active.
  int pulse_highs;
  int value_errs;
  int other_errs;
  int cycles;
  int cycle_limit;
  int frames_done;
  int pulses_done;

  eth_tx_top #(.buf_depth(buf_depth)) dut (
    .CLK(CLK), .RST(RST), .buf_we(buf_we), .buf_waddr(buf_waddr), .buf_wdata(buf_wdata),
    .send_req(send_req), .send_pulse(send_pulse), .send_len(send_len),
    .send_ack(send_ack), .tx_wire(tx_wire), .tx_active(tx_active)
  );

  initial CLK = 1'b0;
  always #50 CLK = !CLK;

  // half-bit sampler, mid cycle.
  always @(negedge CLK)
  begin
    if (tx_active)
      halves.push_back(tx_wire);
    else if (tx_wire)
      pulse_highs++;  // wire high outside a frame.
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      print_counts();
      $display("Test failed");
      $finish;
    end
  end

  task automatic print_counts();
    $display({"summary: %0d frames, %0d pulses, %0d value errors, %0d other errors, ",
              "%0d assertion failures"},
             frames_done, pulses_done, value_errs, other_errs, dut.u_props.fail_cnt);
  endtask

  task automatic note_failure(input string msg);
    other_errs++;
    $display("%s", msg);
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_fcs(input string name, input eth_tx_pkg::crc_t got,
                           input eth_tx_pkg::crc_t exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // golden command layout: type, length, payload words, fcs.
  function automatic int next_cmd(int p);
    return p + 3 + (int'(gold[p + 1]) + 3) / 4;
  endfunction

  function automatic logic [7:0] payload_byte(int p, int k);
    eth_tx_pkg::word_t w;
    w = gold[p + 2 + k / 4];
    return w[31 - 8 * (k % 4) -: 8];  // msb first within a word.
  endfunction

  function automatic eth_tx_pkg::crc_t reference_fcs(int p, int len);
    eth_tx_pkg::crc_t c;
    logic [7:0] d;
    c = eth_tx_pkg::crc_init;
    for (int k = 0; k < len; k++)
    begin
      d = payload_byte(p, k);
      for (int b = 0; b < 8; b++)
      begin
        if (c[0] ^ d[b])
          c = (c >> 1) ^ eth_tx_pkg::crc_poly;
        else
          c = c >> 1;
      end
    end
    return ~c;
  endfunction

  function automatic int budget_cycles();
    int p;
    int len;
    int total;
    p = 0;
    total = 108;  // reset and idle checks.
    while (p < gold_size - 3 && (gold[p] === 32'd0 || gold[p] === 32'd1))
    begin
      len = gold[p + 1];
      total += 16 * (hdr_octets + len + 4) + 64 + (len + 3) / 4 + max_gap + 4;
      p = next_cmd(p);
    end
    return total;
  endfunction

  task automatic load_payload(input int p, input int nw);
    for (int i = 0; i < nw; i++)
    begin
      @(posedge CLK);
      #1;
      buf_we = 1'b1;
      buf_waddr = addr_w'(i);
      buf_wdata = gold[p + 2 + i];
    end
    @(posedge CLK);
    #1;
    buf_we = 1'b0;
  endtask

  // four-phase request, ack, release.
  task automatic handshake(input logic pulse_cmd, input eth_tx_pkg::len_t len);
    int hold;
    @(posedge CLK);
    #1;
    send_pulse = pulse_cmd;
    send_len = len;
    send_req = 1'b1;
    @(negedge CLK);
    while (!send_ack)
      @(negedge CLK);
    check_level("tx_wire", tx_wire, 1'b0);
    check_level("tx_active", tx_active, 1'b0);
    hold = 1 + ($urandom % 3);
    repeat (hold)
    begin
      @(negedge CLK);
      check_level("send_ack", send_ack, 1'b1);
    end
    @(posedge CLK);
    #1;
    send_req = 1'b0;
    @(negedge CLK);
    while (send_ack)
      @(negedge CLK);
    check_level("tx_wire", tx_wire, 1'b0);
  endtask

  task automatic decode_frame(input int p, input int len);
    int nbytes;
    int nbits;
    int idx;
    logic [7:0] got;
    logic [7:0] exp;
    eth_tx_pkg::crc_t fcs_got;
    nbytes = hdr_octets + len + 4;
    nbits = 8 * nbytes;
    fcs_got = '0;
    if (halves.size() != 2 * nbits + 2 * eth_tx_pkg::eot_bits)
      note_failure($sformatf("frame %0d has %0d half-bits while tx_active, expected %0d",
                             frames_done, halves.size(), 2 * nbits + 2 * eth_tx_pkg::eot_bits));
    if (halves.size() < 2 * nbits)
      return;
    for (int k = 0; k < nbytes; k++)
    begin
      got = '0;
      for (int b = 0; b < 8; b++)
      begin
        idx = 2 * (8 * k + b);
        if (halves[idx] === halves[idx + 1])
          note_failure($sformatf("frame %0d byte %0d bit %0d has no mid-bit transition",
                                 frames_done, k, b));
        got[b] = halves[idx + 1];  // second half carries the bit.
      end
      if (k < eth_tx_pkg::preamble_octets)
        exp = eth_tx_pkg::preamble_byte;
      else if (k < hdr_octets)
        exp = eth_tx_pkg::sfd_byte;
      else if (k < hdr_octets + len)
        exp = payload_byte(p, k - hdr_octets);
      if (k < hdr_octets + len)
        check_byte($sformatf("tx_wire byte %0d", k), got, exp);
      else
        fcs_got[8 * (k - hdr_octets - len) +: 8] = got;  // fcs lsb first.
    end
    check_fcs("tx_wire fcs", fcs_got, gold[p + 2 + (len + 3) / 4]);
    for (int i = 2 * nbits; i < halves.size(); i++)
      check_level("tx_wire end high", halves[i], 1'b1);
  endtask

  task automatic run_frame(input int p);
    int len;
    int nw;
    len = gold[p + 1];
    nw = (len + 3) / 4;
    check_fcs("reference crc", reference_fcs(p, len), gold[p + 2 + nw]);
    load_payload(p, nw);
    halves.delete();
    pulse_highs = 0;
    handshake(1'b0, eth_tx_pkg::len_t'(len));
    decode_frame(p, len);
    if (pulse_highs != 0)
      note_failure($sformatf("frame %0d drove tx_wire high outside tx_active", frames_done));
    frames_done++;
  endtask

  task automatic run_pulse();
    halves.delete();
    pulse_highs = 0;
    handshake(1'b1, '0);
    if (pulse_highs != 2)
      note_failure($sformatf("link pulse %0d lasted %0d clocks instead of 2",
                             pulses_done, pulse_highs));
    if (halves.size() != 0)
      note_failure($sformatf("tx_active went high during link pulse %0d", pulses_done));
    pulses_done++;
  endtask

  initial
  begin
    int p;
    RST = 1'b0;
    buf_we = 1'b0;
    buf_waddr = '0;
    buf_wdata = '0;
    send_req = 1'b0;
    send_pulse = 1'b0;
    send_len = '0;
    pulse_highs = 0;
    value_errs = 0;
    other_errs = 0;
    cycles = 0;
    frames_done = 0;
    pulses_done = 0;
    void'($urandom(98));
    $readmemh("tb/eth_tx_golden.hex", gold);
    cycle_limit = budget_cycles();

    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b1;

    // quiet line before the first request.
    repeat (4)
    begin
      @(negedge CLK);
      check_level("tx_wire", tx_wire, 1'b0);
      check_level("tx_active", tx_active, 1'b0);
      check_level("send_ack", send_ack, 1'b0);
    end

    p = 0;
    while (p < gold_size - 3 && (gold[p] === 32'd0 || gold[p] === 32'd1))
    begin
      if (gold[p] === 32'd0)
        run_frame(p);
      else
        run_pulse();
      p = next_cmd(p);
      repeat ($urandom % max_gap) @(posedge CLK);
    end
    if (p >= gold_size - 3 || gold[p] !== 32'd2)
      note_failure("golden file has an unknown command type or no end marker");
    if (frames_done + pulses_done == 0)
      note_failure("no commands were found in the golden file");

    repeat (2) @(posedge CLK);
    print_counts();
    if (value_errs + other_errs + dut.u_props.fail_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule
